// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= pdu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/pdu_tb.sv ====
`timescale 1ns/100ps

module pdu_tb;

    // Worst case flit count over all tests, used to size the timeout.
    localparam int TOTAL_FLITS = 1 + 32 + 6 * 8 + 3 * 16 + 14;
    localparam int CYCLE_LIMIT = 20 * TOTAL_FLITS + 2000;

    logic        clk;
    logic        rst;
    logic        in_valid [2];
    logic        in_sop [2];
    logic        in_eop [2];
    logic [63:0] in_data [2];
    logic [2:0]  in_empty [2];
    logic        in_ready [2];
    logic        meta_valid [2];
    logic [7:0]  meta_queue [2];
    logic        meta_ready [2];
    logic        pkt_rd_en;
    logic [65:0] pkt_rd_data;
    logic        pkt_not_empty;
    logic        desc_rd_en;
    logic [20:0] desc_rd_data;
    logic        desc_not_empty;

    logic [65:0] cur0 [$];
    logic [65:0] cur1 [$];
    logic [20:0] cur_desc [2];
    logic [65:0] exp_pkt [$];
    logic [20:0] exp_desc [$];
    logic        host_en;
    logic        alt_check;
    int          last_port;
    int          errors;
    int          checks;
    int          cycles;

    pdu_top dut0 (
        .clk(clk), .rst(rst),
        .p0_in_valid(in_valid[0]), .p0_in_sop(in_sop[0]), .p0_in_eop(in_eop[0]),
        .p0_in_data(in_data[0]), .p0_in_empty(in_empty[0]), .p0_in_ready(in_ready[0]),
        .p0_in_meta_valid(meta_valid[0]), .p0_in_meta_queue(meta_queue[0]),
        .p0_in_meta_ready(meta_ready[0]),
        .p1_in_valid(in_valid[1]), .p1_in_sop(in_sop[1]), .p1_in_eop(in_eop[1]),
        .p1_in_data(in_data[1]), .p1_in_empty(in_empty[1]), .p1_in_ready(in_ready[1]),
        .p1_in_meta_valid(meta_valid[1]), .p1_in_meta_queue(meta_queue[1]),
        .p1_in_meta_ready(meta_ready[1]),
        .pkt_rd_en(pkt_rd_en), .pkt_rd_data(pkt_rd_data), .pkt_not_empty(pkt_not_empty),
        .desc_rd_en(desc_rd_en), .desc_rd_data(desc_rd_data),
        .desc_not_empty(desc_not_empty)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing.", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [65:0] got, input logic [65:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [63:0] byte_reverse(input logic [63:0] d);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return r;
    endfunction

    // A completed packet goes to the expected stream in completion order.
    always @(negedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (!rst && meta_ready[p]) begin
                if (p == 0) begin
                    foreach (cur0[i]) exp_pkt.push_back(cur0[i]);
                end else begin
                    foreach (cur1[i]) exp_pkt.push_back(cur1[i]);
                end
                exp_desc.push_back(cur_desc[p]);
                if (alt_check && last_port >= 0) begin
                    check("completed port", 66'(p), 66'(1 - last_port));
                end
                last_port = p;
            end
        end
    end

    // Host reader; takes an entry only once its expected value is known.
    always begin
        logic take_pkt;
        logic take_desc;
        @(negedge clk);
        take_pkt  = host_en && pkt_not_empty && (exp_pkt.size() > 0);
        take_desc = host_en && desc_not_empty && (exp_desc.size() > 0);
        if (take_pkt) begin
            check("pkt_rd_data", pkt_rd_data, exp_pkt.pop_front());
        end
        if (take_desc) begin
            check("desc_rd_data", 66'(desc_rd_data), 66'(exp_desc.pop_front()));
        end
        @(posedge clk);
        pkt_rd_en  <= take_pkt;
        desc_rd_en <= take_desc;
        if (take_pkt || take_desc) begin
            @(posedge clk);
            pkt_rd_en  <= 1'b0;
            desc_rd_en <= 1'b0;
        end
    end

    task automatic send_pkt(input int port, input int nflits, input int empty,
                            input int stall_at);
        logic [63:0] d [$];
        logic [7:0]  q;
        q = 8'($urandom);
        if (port == 0) cur0.delete();
        else cur1.delete();
        for (int i = 0; i < nflits; i++) begin
            d.push_back({$urandom, $urandom});
            if (port == 0) cur0.push_back({i == 0, i == nflits - 1, byte_reverse(d[i])});
            else cur1.push_back({i == 0, i == nflits - 1, byte_reverse(d[i])});
        end
        cur_desc[port] = {port[0], q, 12'(8 * nflits - empty)};
        @(posedge clk);
        meta_valid[port] <= 1'b1;
        meta_queue[port] <= q;
        for (int i = 0; i < nflits; i++) begin
            if (i == stall_at) begin
                in_valid[port] <= 1'b0;
                repeat (6) @(posedge clk);
            end
            in_valid[port] <= 1'b1;
            in_sop[port]   <= (i == 0);
            in_eop[port]   <= (i == nflits - 1);
            in_data[port]  <= d[i];
            in_empty[port] <= (i == nflits - 1) ? 3'(empty) : 3'd0;
            do @(negedge clk); while (!in_ready[port]);
            @(posedge clk);
        end
        in_valid[port] <= 1'b0;
        do @(negedge clk); while (!meta_ready[port]);
        @(posedge clk);
        meta_valid[port] <= 1'b0;
    endtask

    task automatic wait_drain();
        do @(negedge clk); while (exp_pkt.size() > 0 || exp_desc.size() > 0);
        repeat (4) @(negedge clk);
        check("pkt_not_empty", 66'(pkt_not_empty), 66'(0));
        check("desc_not_empty", 66'(desc_not_empty), 66'(0));
    endtask

    task automatic report(input string name, input int errs_before);
        $display("%s: %s", name, (errors == errs_before) ? "passed" : "failed");
    endtask

    task automatic single_flit_test();
        int e0;
        e0 = errors;
        send_pkt(0, 1, 3, -1);
        wait_drain();
        report("single flit on port 0", e0);
    endtask

    task automatic multi_flit_test();
        int e0;
        e0 = errors;
        send_pkt(1, 2 + $urandom_range(30), $urandom_range(7), -1);
        wait_drain();
        report("multi flit on port 1", e0);
    endtask

    task automatic contention_test();
        int e0;
        e0 = errors;
        last_port = 1; // Port 1 was served last, in the multi-flit test.
        alt_check = 1'b1;
        fork
            for (int k = 0; k < 3; k++) send_pkt(0, 1 + $urandom_range(7), $urandom_range(7), -1);
            for (int k = 0; k < 3; k++) send_pkt(1, 1 + $urandom_range(7), $urandom_range(7), -1);
        join
        wait_drain();
        alt_check = 1'b0;
        report("both ports under contention", e0);
    endtask

    task automatic backpressure_test();
        int e0;
        e0 = errors;
        host_en = 1'b0;
        send_pkt(0, 16, 0, -1);
        send_pkt(0, 16, 2, -1);
        fork
            send_pkt(0, 16, 5, -1);
            begin
                repeat (50) begin
                    @(negedge clk);
                    check("p0_in_ready", 66'(in_ready[0]), 66'(0));
                end
                host_en = 1'b1;
            end
        join
        wait_drain();
        report("back-pressure with host stopped", e0);
    endtask

    task automatic stall_test();
        int e0;
        e0 = errors;
        fork
            send_pkt(0, 10, 1, 4);
            begin
                repeat (3) @(posedge clk);
                send_pkt(1, 4, 6, -1);
            end
            begin
                do begin // Port 1 is shut out while port 0 owns the buffers.
                    @(negedge clk);
                    if (in_ready[0]) begin
                        check("p1_in_ready", 66'(in_ready[1]), 66'(0));
                    end
                end while (!meta_ready[0]);
            end
        join
        wait_drain();
        report("source stall on port 0", e0);
    endtask

    initial begin
        void'($urandom(32'he424_6fca));
        clk = 1'b0;
        rst = 1'b1;
        cycles = 0;
        errors = 0;
        checks = 0;
        host_en = 1'b1;
        alt_check = 1'b0;
        last_port = -1;
        pkt_rd_en = 1'b0;
        desc_rd_en = 1'b0;
        for (int p = 0; p < 2; p++) begin
            in_valid[p] = 1'b0;
            in_sop[p] = 1'b0;
            in_eop[p] = 1'b0;
            in_data[p] = '0;
            in_empty[p] = '0;
            meta_valid[p] = 1'b0;
            meta_queue[p] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        single_flit_test();
        multi_flit_test();
        contention_test();
        backpressure_test();
        stall_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/pdu_pkg.sv
rtl/sync_fifo.sv
rtl/pdu_gen.sv
rtl/buf_arbiter.sv
rtl/pdu_top.sv
bench/pdu_tb.sv

// ==== rtl/buf_arbiter.sv ====
`timescale 1ns/100ps

module buf_arbiter import pdu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req0,
    input  logic                       req1,
    output logic                       ack0,
    output logic                       ack1,
    input  logic                       pkt0_wr_en,
    input  logic [PKT_ENTRY_WIDTH-1:0] pkt0_wr_data,
    input  logic                       desc0_wr_en,
    input  logic [DESC_WIDTH-1:0]      desc0_wr_data,
    input  logic                       pkt1_wr_en,
    input  logic [PKT_ENTRY_WIDTH-1:0] pkt1_wr_data,
    input  logic                       desc1_wr_en,
    input  logic [DESC_WIDTH-1:0]      desc1_wr_data,
    output logic                       pkt_wr_en,
    output logic [PKT_ENTRY_WIDTH-1:0] pkt_wr_data,
    output logic                       desc_wr_en,
    output logic [DESC_WIDTH-1:0]      desc_wr_data
);

    // Current or most recent owner, which is also the last port served.
    logic owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack0  <= 1'b0;
            ack1  <= 1'b0;
            owner <= 1'b1; // Port 0 wins the first contention.
        end else if (ack0) begin
            if (!req0) begin
                ack0 <= 1'b0;
            end
        end else if (ack1) begin
            if (!req1) begin
                ack1 <= 1'b0;
            end
        end else if (req0 && (!req1 || owner)) begin
            ack0  <= 1'b1;
            owner <= 1'b0;
        end else if (req1) begin
            ack1  <= 1'b1;
            owner <= 1'b1;
        end
    end

    always_comb begin
        if (owner) begin
            pkt_wr_en    = ack1 && pkt1_wr_en;
            pkt_wr_data  = pkt1_wr_data;
            desc_wr_en   = ack1 && desc1_wr_en;
            desc_wr_data = desc1_wr_data;
        end else begin
            pkt_wr_en    = ack0 && pkt0_wr_en;
            pkt_wr_data  = pkt0_wr_data;
            desc_wr_en   = ack0 && desc0_wr_en;
            desc_wr_data = desc0_wr_data;
        end
    end

endmodule

// ==== rtl/pdu_gen.sv ====
`timescale 1ns/100ps

module pdu_gen import pdu_pkg::*; #(
    parameter int PORT_ID    = 0,
    parameter int PKT_DEPTH  = PKT_DEPTH_DEFAULT,
    parameter int DESC_DEPTH = DESC_DEPTH_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_sop,
    input  logic                            in_eop,
    input  logic                            in_valid,
    input  logic [FLIT_WIDTH-1:0]           in_data,
    input  logic [EMPTY_WIDTH-1:0]          in_empty,
    output logic                            in_ready,
    input  logic                            in_meta_valid,
    input  logic [QUEUE_WIDTH-1:0]          in_meta_queue,
    output logic                            in_meta_ready,
    output logic                            buf_req,
    input  logic                            buf_ack,
    output logic                            pkt_wr_en,
    output logic [PKT_ENTRY_WIDTH-1:0]      pkt_wr_data,
    input  logic [$clog2(PKT_DEPTH+1)-1:0]  pkt_occup,
    output logic                            desc_wr_en,
    output logic [DESC_WIDTH-1:0]           desc_wr_data,
    input  logic [$clog2(DESC_DEPTH+1)-1:0] desc_occup
);

    typedef enum logic [1:0] {
        IDLE,
        ACQUIRE,
        WRITE,
        RELEASE
    } state_t;

    state_t                  state;
    logic                    space_ok;
    logic [1:0]              rel_cnt;
    logic [SIZE_WIDTH-1:0]   size_cnt;

    // First pipeline stage holds the raw flit.
    logic                    wr_r;
    logic                    sop_r;
    logic                    eop_r;
    logic [FLIT_WIDTH-1:0]   data_r;
    logic [FLIT_WIDTH-1:0]   data_swap;
    logic [DESC_WIDTH-1:0]   desc_r;

    assign in_ready = (state == WRITE);

    always_comb begin
        for (int i = 0; i < FLIT_BYTES; i++) begin
            data_swap[8*i +: 8] = data_r[8*(FLIT_BYTES-1-i) +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            buf_req       <= 1'b0;
            in_meta_ready <= 1'b0;
            wr_r          <= 1'b0;
            space_ok      <= 1'b0;
            rel_cnt       <= '0;
            size_cnt      <= '0;
        end else begin
            wr_r          <= 1'b0;
            in_meta_ready <= 1'b0;
            space_ok      <= (int'(pkt_occup) + PKT_SPACE_MIN <= PKT_DEPTH) &&
                             (int'(desc_occup) + DESC_SPACE_MIN <= DESC_DEPTH);
            case (state)
                IDLE: begin
                    if (in_meta_valid && !buf_ack) begin // Previous ack must be gone.
                        buf_req <= 1'b1;
                        state   <= ACQUIRE;
                    end
                end
                ACQUIRE: begin
                    if (buf_ack && space_ok) begin
                        size_cnt <= '0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    if (in_valid) begin
                        wr_r <= 1'b1;
                        if (in_eop) begin
                            in_meta_ready <= 1'b1;
                            size_cnt      <= '0;
                            rel_cnt       <= '0;
                            state         <= RELEASE;
                        end else begin
                            size_cnt <= size_cnt + SIZE_WIDTH'(FLIT_BYTES);
                        end
                    end
                end
                RELEASE: begin
                    rel_cnt <= rel_cnt + 1'b1;
                    if (rel_cnt == 2'd2) begin // Last write landed one edge ago.
                        buf_req <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_r <= in_data;
            sop_r  <= in_sop;
            eop_r  <= in_eop;
            if (in_eop) begin
                desc_r[DESC_PORT_BIT]                  <= 1'(PORT_ID);
                desc_r[DESC_QUEUE_LSB +: QUEUE_WIDTH]  <= in_meta_queue;
                desc_r[DESC_SIZE_LSB +: SIZE_WIDTH]    <= size_cnt + SIZE_WIDTH'(FLIT_BYTES)
                                                          - SIZE_WIDTH'(in_empty);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_wr_en  <= 1'b0;
            desc_wr_en <= 1'b0;
        end else begin
            pkt_wr_en  <= wr_r;
            desc_wr_en <= in_meta_ready; // Lines up with the eop flit write.
        end
    end

    always_ff @(posedge clk) begin
        pkt_wr_data[PKT_SOP_BIT]         <= sop_r;
        pkt_wr_data[PKT_EOP_BIT]         <= eop_r;
        pkt_wr_data[FLIT_WIDTH-1:0]      <= data_swap;
        desc_wr_data                     <= desc_r;
    end

endmodule

// ==== rtl/pdu_pkg.sv ====
package pdu_pkg;

    // Flit format on the ingress ports.
    localparam int FLIT_WIDTH  = 64;
    localparam int FLIT_BYTES  = FLIT_WIDTH / 8;
    localparam int EMPTY_WIDTH = 3;

    // Metadata and descriptor fields.
    localparam int QUEUE_WIDTH = 8;
    localparam int SIZE_WIDTH  = 12;

    localparam int MAX_PKT_FLITS = 32;

    // Packet buffer entry is {sop, eop, data}.
    localparam int PKT_ENTRY_WIDTH = FLIT_WIDTH + 2;
    localparam int PKT_SOP_BIT     = FLIT_WIDTH + 1;
    localparam int PKT_EOP_BIT     = FLIT_WIDTH;

    // Descriptor is {port, queue, size}, high to low.
    localparam int DESC_WIDTH     = 1 + QUEUE_WIDTH + SIZE_WIDTH;
    localparam int DESC_PORT_BIT  = DESC_WIDTH - 1;
    localparam int DESC_QUEUE_LSB = SIZE_WIDTH;
    localparam int DESC_SIZE_LSB  = 0;

    // Generator needs room for a whole packet plus its pipeline.
    localparam int PKT_SPACE_MIN  = MAX_PKT_FLITS + 2;
    localparam int DESC_SPACE_MIN = 2;

    localparam int PKT_DEPTH_DEFAULT  = 64;
    localparam int DESC_DEPTH_DEFAULT = 16;

endpackage

// ==== rtl/pdu_top.sv ====
`timescale 1ns/100ps

module pdu_top import pdu_pkg::*; #(
    parameter int PKT_DEPTH  = PKT_DEPTH_DEFAULT,
    parameter int DESC_DEPTH = DESC_DEPTH_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       p0_in_valid,
    input  logic                       p0_in_sop,
    input  logic                       p0_in_eop,
    input  logic [FLIT_WIDTH-1:0]      p0_in_data,
    input  logic [EMPTY_WIDTH-1:0]     p0_in_empty,
    output logic                       p0_in_ready,
    input  logic                       p0_in_meta_valid,
    input  logic [QUEUE_WIDTH-1:0]     p0_in_meta_queue,
    output logic                       p0_in_meta_ready,
    input  logic                       p1_in_valid,
    input  logic                       p1_in_sop,
    input  logic                       p1_in_eop,
    input  logic [FLIT_WIDTH-1:0]      p1_in_data,
    input  logic [EMPTY_WIDTH-1:0]     p1_in_empty,
    output logic                       p1_in_ready,
    input  logic                       p1_in_meta_valid,
    input  logic [QUEUE_WIDTH-1:0]     p1_in_meta_queue,
    output logic                       p1_in_meta_ready,
    input  logic                       pkt_rd_en,
    output logic [PKT_ENTRY_WIDTH-1:0] pkt_rd_data,
    output logic                       pkt_not_empty,
    input  logic                       desc_rd_en,
    output logic [DESC_WIDTH-1:0]      desc_rd_data,
    output logic                       desc_not_empty
);

    logic                            req0, req1, ack0, ack1;
    logic                            pkt0_wr_en, pkt1_wr_en, pkt_wr_en;
    logic                            desc0_wr_en, desc1_wr_en, desc_wr_en;
    logic [PKT_ENTRY_WIDTH-1:0]      pkt0_wr_data, pkt1_wr_data, pkt_wr_data;
    logic [DESC_WIDTH-1:0]           desc0_wr_data, desc1_wr_data, desc_wr_data;
    logic [$clog2(PKT_DEPTH+1)-1:0]  pkt_occup;
    logic [$clog2(DESC_DEPTH+1)-1:0] desc_occup;

    pdu_gen #(.PORT_ID(0), .PKT_DEPTH(PKT_DEPTH), .DESC_DEPTH(DESC_DEPTH)) u_gen0 (
        .clk(clk), .rst(rst),
        .in_sop(p0_in_sop), .in_eop(p0_in_eop), .in_valid(p0_in_valid),
        .in_data(p0_in_data), .in_empty(p0_in_empty), .in_ready(p0_in_ready),
        .in_meta_valid(p0_in_meta_valid), .in_meta_queue(p0_in_meta_queue),
        .in_meta_ready(p0_in_meta_ready),
        .buf_req(req0), .buf_ack(ack0),
        .pkt_wr_en(pkt0_wr_en), .pkt_wr_data(pkt0_wr_data), .pkt_occup(pkt_occup),
        .desc_wr_en(desc0_wr_en), .desc_wr_data(desc0_wr_data), .desc_occup(desc_occup)
    );

    pdu_gen #(.PORT_ID(1), .PKT_DEPTH(PKT_DEPTH), .DESC_DEPTH(DESC_DEPTH)) u_gen1 (
        .clk(clk), .rst(rst),
        .in_sop(p1_in_sop), .in_eop(p1_in_eop), .in_valid(p1_in_valid),
        .in_data(p1_in_data), .in_empty(p1_in_empty), .in_ready(p1_in_ready),
        .in_meta_valid(p1_in_meta_valid), .in_meta_queue(p1_in_meta_queue),
        .in_meta_ready(p1_in_meta_ready),
        .buf_req(req1), .buf_ack(ack1),
        .pkt_wr_en(pkt1_wr_en), .pkt_wr_data(pkt1_wr_data), .pkt_occup(pkt_occup),
        .desc_wr_en(desc1_wr_en), .desc_wr_data(desc1_wr_data), .desc_occup(desc_occup)
    );

    buf_arbiter u_arb (
        .clk(clk), .rst(rst),
        .req0(req0), .req1(req1), .ack0(ack0), .ack1(ack1),
        .pkt0_wr_en(pkt0_wr_en), .pkt0_wr_data(pkt0_wr_data),
        .desc0_wr_en(desc0_wr_en), .desc0_wr_data(desc0_wr_data),
        .pkt1_wr_en(pkt1_wr_en), .pkt1_wr_data(pkt1_wr_data),
        .desc1_wr_en(desc1_wr_en), .desc1_wr_data(desc1_wr_data),
        .pkt_wr_en(pkt_wr_en), .pkt_wr_data(pkt_wr_data),
        .desc_wr_en(desc_wr_en), .desc_wr_data(desc_wr_data)
    );

    sync_fifo #(.WIDTH(PKT_ENTRY_WIDTH), .DEPTH(PKT_DEPTH)) u_pkt_fifo (
        .clk(clk), .rst(rst),
        .wr_en(pkt_wr_en), .wr_data(pkt_wr_data),
        .rd_en(pkt_rd_en), .rd_data(pkt_rd_data),
        .not_empty(pkt_not_empty), .occup(pkt_occup)
    );

    sync_fifo #(.WIDTH(DESC_WIDTH), .DEPTH(DESC_DEPTH)) u_desc_fifo (
        .clk(clk), .rst(rst),
        .wr_en(desc_wr_en), .wr_data(desc_wr_data),
        .rd_en(desc_rd_en), .rd_data(desc_rd_data),
        .not_empty(desc_not_empty), .occup(desc_occup)
    );

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  logic [WIDTH-1:0]           wr_data,
    input  logic                       rd_en,
    output logic [WIDTH-1:0]           rd_data,
    output logic                       not_empty,
    output logic [$clog2(DEPTH+1)-1:0] occup
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && (occup != DEPTH[$clog2(DEPTH+1)-1:0]); // Full writes are dropped.
    assign do_rd = rd_en && not_empty;

    assign not_empty = (occup != '0);
    assign rd_data   = mem[rd_ptr]; // Head of the queue is always on the output.

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occup  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                occup <= occup + 1'b1;
            end else if (do_rd && !do_wr) begin
                occup <= occup - 1'b1;
            end
        end
    end

endmodule
